//--- all.f
+incdir+testbench
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/decode_stage.sv
hw/uop_queue.sv
hw/exec_unit.sv
hw/idu_core.sv
testbench/tb_idu_core.sv

//--- hw/core_cfg_pkg.sv
package core_cfg_pkg;

    // ====================
    // execute unit types
    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE, SHIFT, HALTED
    } exec_state_e;

    localparam int ALU_OP_W  = 4;
    localparam int GPR_IDX_W = 4;

    // micro-op queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = 2;

    // ====================
    // micro-op word layout
    localparam int UOP_ALU_LSB      = 0;
    localparam int UOP_SRC1_PC_LSB  = 4;
    localparam int UOP_SRC2_IMM_LSB = 5;
    localparam int UOP_RD_LSB       = 6;
    localparam int UOP_RS1_LSB      = 10;
    localparam int UOP_RS2_LSB      = 14;
    localparam int UOP_WE_LSB       = 18;
    localparam int UOP_HALT_LSB     = 19;
    localparam int UOP_ILLEGAL_LSB  = 20;
    localparam int UOP_IMM_LSB      = 21;
    localparam int UOP_PC_LSB       = 53;
    localparam int UOP_SPARE_LSB    = 85;
    // padding up to 112 bits, always zero
    localparam int UOP_SPARE_W      = 27;
    localparam int UOP_W            = UOP_SPARE_LSB + UOP_SPARE_W;

    typedef logic [UOP_W-1:0] uop_word_t;

endpackage

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     inst_valid_i,
    input  rv_isa_pkg::inst_t        inst_i,
    input  rv_isa_pkg::pc_t          pc_i,
    output logic                     uop_valid_o,
    output core_cfg_pkg::uop_word_t  uop_word_o
);

    // ====================
    // instruction fields
    logic [6:0]            opcode;
    rv_isa_pkg::reg_idx_t  rd;
    rv_isa_pkg::reg_idx_t  rs1;
    rv_isa_pkg::reg_idx_t  rs2;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_t   funct7;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    // decoded controls
    core_cfg_pkg::alu_op_e   alu_op;
    logic                    src1_pc;
    logic                    src2_imm;
    rv_isa_pkg::word_t       imm;
    logic                    writes;
    logic                    halt;
    logic                    legal;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    bad_reg;
    logic                    illegal;
    logic                    we;
    core_cfg_pkg::uop_word_t uop_d;

    // shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic core_cfg_pkg::alu_op_e alu_from_f3(input rv_isa_pkg::funct3_t f3,
                                                          input logic alt);
        case (f3)
            rv_isa_pkg::F3_ADD:  return alt ? core_cfg_pkg::SUB : core_cfg_pkg::ADD;
            rv_isa_pkg::F3_SLL:  return core_cfg_pkg::SLL;
            rv_isa_pkg::F3_SLT:  return core_cfg_pkg::SLT;
            rv_isa_pkg::F3_SLTU: return core_cfg_pkg::SLTU;
            rv_isa_pkg::F3_XOR:  return core_cfg_pkg::XOR;
            rv_isa_pkg::F3_SR:   return alt ? core_cfg_pkg::SRA : core_cfg_pkg::SRL;
            rv_isa_pkg::F3_OR:   return core_cfg_pkg::OR;
            default:             return core_cfg_pkg::AND;
        endcase
    endfunction

    // ====================
    // opcode classification
    always_comb begin
        alu_op   = core_cfg_pkg::ADD;
        src1_pc  = 1'b0;
        src2_imm = 1'b0;
        imm      = '0;
        writes   = 1'b0;
        halt     = 1'b0;
        legal    = 1'b0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM: begin
                alu_op   = alu_from_f3(funct3, (funct3 == rv_isa_pkg::F3_SR) & inst_i[30]);
                src2_imm = 1'b1;
                writes   = 1'b1;
                use_rs1  = 1'b1;
                if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SR) begin
                    // shamt only, upper bits pick the shift kind
                    imm   = {27'b0, inst_i[24:20]};
                    legal = (funct7 == rv_isa_pkg::F7_BASE) ||
                            (funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_SR);
                end else begin
                    imm   = {{20{inst_i[31]}}, inst_i[31:20]};
                    legal = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP: begin
                alu_op  = alu_from_f3(funct3, funct7 == rv_isa_pkg::F7_ALT);
                writes  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                legal   = (funct7 == rv_isa_pkg::F7_BASE) ||
                          (funct7 == rv_isa_pkg::F7_ALT &&
                           (funct3 == rv_isa_pkg::F3_ADD || funct3 == rv_isa_pkg::F3_SR));
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op   = core_cfg_pkg::PASS;
                src2_imm = 1'b1;
                imm      = {inst_i[31:12], 12'b0};
                writes   = 1'b1;
                legal    = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                src1_pc  = 1'b1;
                src2_imm = 1'b1;
                imm      = {inst_i[31:12], 12'b0};
                writes   = 1'b1;
                legal    = 1'b1;
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                // only EBREAK, ECALL MRET and CSRs stay illegal
                legal = (funct3 == 3'b000) && (rd == '0) && (rs1 == '0) &&
                        (inst_i[31:20] == rv_isa_pkg::IMM_EBREAK);
                halt  = legal;
            end
            rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_BRANCH,
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                // no memory or control transfer in this slice
                legal = 1'b0;
            end
            default: legal = 1'b0;
        endcase
    end

    // x16 and up do not exist on RV32E
    assign bad_reg = (writes  && rd  >= rv_isa_pkg::NUM_GPR) ||
                     (use_rs1 && rs1 >= rv_isa_pkg::NUM_GPR) ||
                     (use_rs2 && rs2 >= rv_isa_pkg::NUM_GPR);
    assign illegal = !legal || bad_reg;
    assign we      = writes && !illegal && (rd != '0);

    // pack the micro-op, spare bits stay zero
    always_comb begin
        uop_d = '0;
        uop_d[core_cfg_pkg::UOP_ALU_LSB +: core_cfg_pkg::ALU_OP_W]  = alu_op;
        uop_d[core_cfg_pkg::UOP_SRC1_PC_LSB]                        = src1_pc;
        uop_d[core_cfg_pkg::UOP_SRC2_IMM_LSB]                       = src2_imm;
        uop_d[core_cfg_pkg::UOP_RD_LSB  +: core_cfg_pkg::GPR_IDX_W] = rd[3:0];
        uop_d[core_cfg_pkg::UOP_RS1_LSB +: core_cfg_pkg::GPR_IDX_W] = rs1[3:0];
        uop_d[core_cfg_pkg::UOP_RS2_LSB +: core_cfg_pkg::GPR_IDX_W] = rs2[3:0];
        uop_d[core_cfg_pkg::UOP_WE_LSB]                             = we;
        uop_d[core_cfg_pkg::UOP_HALT_LSB]                           = halt && !illegal;
        uop_d[core_cfg_pkg::UOP_ILLEGAL_LSB]                        = illegal;
        uop_d[core_cfg_pkg::UOP_IMM_LSB +: 32]                      = imm;
        uop_d[core_cfg_pkg::UOP_PC_LSB  +: 32]                      = pc_i;
    end

    // ====================
    // decode register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            uop_valid_o <= 1'b0;
        end else begin
            uop_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            uop_word_o <= uop_d;
        end
    end

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     empty_i,
    input  core_cfg_pkg::uop_word_t  uop_i,
    output logic                     pop_o,
    output logic                     retire_o,
    output rv_isa_pkg::pc_t          retire_pc_o,
    output logic                     retire_illegal_o,
    output logic                     wb_we_o,
    output rv_isa_pkg::reg_idx_t     wb_rd_o,
    output rv_isa_pkg::word_t        wb_data_o,
    output logic                     halt_o
);

    // ====================
    // micro-op fields
    core_cfg_pkg::alu_op_e   alu_op;
    logic                    src1_pc;
    logic                    src2_imm;
    logic [3:0]              rd;
    logic [3:0]              rs1;
    logic [3:0]              rs2;
    logic                    we;
    logic                    halt;
    logic                    illegal;
    rv_isa_pkg::word_t       imm;
    rv_isa_pkg::pc_t         pc;

    assign alu_op   = core_cfg_pkg::alu_op_e'(uop_i[core_cfg_pkg::UOP_ALU_LSB +:
                                                    core_cfg_pkg::ALU_OP_W]);
    assign src1_pc  = uop_i[core_cfg_pkg::UOP_SRC1_PC_LSB];
    assign src2_imm = uop_i[core_cfg_pkg::UOP_SRC2_IMM_LSB];
    assign rd       = uop_i[core_cfg_pkg::UOP_RD_LSB  +: core_cfg_pkg::GPR_IDX_W];
    assign rs1      = uop_i[core_cfg_pkg::UOP_RS1_LSB +: core_cfg_pkg::GPR_IDX_W];
    assign rs2      = uop_i[core_cfg_pkg::UOP_RS2_LSB +: core_cfg_pkg::GPR_IDX_W];
    assign we       = uop_i[core_cfg_pkg::UOP_WE_LSB];
    assign halt     = uop_i[core_cfg_pkg::UOP_HALT_LSB];
    assign illegal  = uop_i[core_cfg_pkg::UOP_ILLEGAL_LSB];
    assign imm      = uop_i[core_cfg_pkg::UOP_IMM_LSB +: 32];
    assign pc       = uop_i[core_cfg_pkg::UOP_PC_LSB  +: 32];

    rv_isa_pkg::word_t          rf [rv_isa_pkg::NUM_GPR];
    core_cfg_pkg::exec_state_e  state;
    rv_isa_pkg::word_t          op_a;
    rv_isa_pkg::word_t          op_b;
    rv_isa_pkg::word_t          alu_res;
    logic                       is_shift;
    logic                       start_shift;

    // shifter state, held while in SHIFT
    rv_isa_pkg::word_t          sh_val_q;
    rv_isa_pkg::word_t          sh_next;
    logic [4:0]                 sh_cnt_q;
    core_cfg_pkg::alu_op_e      sh_op_q;
    logic [3:0]                 sh_rd_q;
    logic                       sh_we_q;
    rv_isa_pkg::pc_t            sh_pc_q;

    // retirement of this cycle
    logic                       ret_d;
    logic                       ret_we;
    logic [3:0]                 ret_rd;
    rv_isa_pkg::word_t          ret_data;
    rv_isa_pkg::pc_t            ret_pc;
    logic                       ret_ill;

    assign op_a = src1_pc  ? pc  : rf[rs1];
    assign op_b = src2_imm ? imm : rf[rs2];

    // ====================
    // single-cycle ALU
    always_comb begin
        case (alu_op)
            core_cfg_pkg::ADD:  alu_res = op_a + op_b;
            core_cfg_pkg::SUB:  alu_res = op_a - op_b;
            core_cfg_pkg::SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            core_cfg_pkg::SLTU: alu_res = {31'b0, op_a < op_b};
            core_cfg_pkg::XOR:  alu_res = op_a ^ op_b;
            core_cfg_pkg::OR:   alu_res = op_a | op_b;
            core_cfg_pkg::AND:  alu_res = op_a & op_b;
            core_cfg_pkg::PASS: alu_res = op_b;
            // zero-distance shift gives rs1 back
            default:            alu_res = op_a;
        endcase
    end

    assign is_shift    = (alu_op == core_cfg_pkg::SLL) || (alu_op == core_cfg_pkg::SRL) ||
                         (alu_op == core_cfg_pkg::SRA);
    assign start_shift = is_shift && !illegal && (op_b[4:0] != '0);
    assign pop_o       = (state == core_cfg_pkg::IDLE) && !empty_i;

    // one bit per cycle
    always_comb begin
        case (sh_op_q)
            core_cfg_pkg::SLL: sh_next = {sh_val_q[30:0], 1'b0};
            core_cfg_pkg::SRA: sh_next = {sh_val_q[31], sh_val_q[31:1]};
            default:           sh_next = {1'b0, sh_val_q[31:1]};
        endcase
    end

    always_comb begin
        ret_d    = 1'b0;
        ret_we   = we;
        ret_rd   = rd;
        ret_data = alu_res;
        ret_pc   = pc;
        ret_ill  = illegal;
        if (state == core_cfg_pkg::IDLE) begin
            ret_d = !empty_i && !start_shift;
        end else if (state == core_cfg_pkg::SHIFT) begin
            // last step retires with the shifted value
            ret_d    = (sh_cnt_q == 5'd1);
            ret_we   = sh_we_q;
            ret_rd   = sh_rd_q;
            ret_data = sh_next;
            ret_pc   = sh_pc_q;
            ret_ill  = 1'b0;
        end
    end

    // ====================
    // FSM and shifter
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state  <= core_cfg_pkg::IDLE;
            halt_o <= 1'b0;
        end else begin
            case (state)
                core_cfg_pkg::IDLE: begin
                    if (!empty_i && halt) begin
                        state  <= core_cfg_pkg::HALTED;
                        halt_o <= 1'b1;
                    end else if (!empty_i && start_shift) begin
                        state <= core_cfg_pkg::SHIFT;
                    end
                end
                core_cfg_pkg::SHIFT: begin
                    if (sh_cnt_q == 5'd1) begin
                        state <= core_cfg_pkg::IDLE;
                    end
                end
                default: state <= core_cfg_pkg::HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_cfg_pkg::IDLE) begin
            sh_val_q <= op_a;
            sh_cnt_q <= op_b[4:0];
            sh_op_q  <= alu_op;
            sh_rd_q  <= rd;
            sh_we_q  <= we;
            sh_pc_q  <= pc;
        end else begin
            sh_val_q <= sh_next;
            sh_cnt_q <= sh_cnt_q - 1'b1;
        end
    end

    // register file write and retire outputs on the same edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_o         <= 1'b0;
            retire_illegal_o <= 1'b0;
            wb_we_o          <= 1'b0;
            for (int i = 0; i < rv_isa_pkg::NUM_GPR; i++) begin
                rf[i] <= '0;
            end
        end else begin
            retire_o         <= ret_d;
            retire_illegal_o <= ret_d && ret_ill;
            wb_we_o          <= ret_d && ret_we;
            if (ret_d && ret_we) begin
                rf[ret_rd] <= ret_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret_d) begin
            retire_pc_o <= ret_pc;
            wb_rd_o     <= {1'b0, ret_rd};
            wb_data_o   <= ret_data;
        end
    end

endmodule

//--- hw/idu_core.sv
`timescale 1ns/1ps

module idu_core (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  inst_valid_i,
    input  rv_isa_pkg::inst_t     inst_i,
    input  rv_isa_pkg::pc_t       pc_i,
    output logic                  full_o,
    output logic                  retire_o,
    output rv_isa_pkg::pc_t       retire_pc_o,
    output logic                  retire_illegal_o,
    output logic                  wb_we_o,
    output rv_isa_pkg::reg_idx_t  wb_rd_o,
    output rv_isa_pkg::word_t     wb_data_o,
    output logic                  halt_o
);

    // decode to queue
    logic                     uop_valid;
    core_cfg_pkg::uop_word_t  uop_word;

    // queue to execute
    logic                     q_empty;
    core_cfg_pkg::uop_word_t  q_word;
    logic                     q_pop;

    decode_stage u_decode (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .uop_valid_o  (uop_valid),
        .uop_word_o   (uop_word)
    );

    uop_queue u_queue (
        .clk       (clk),
        .rst_i     (rst_i),
        .wr_i      (uop_valid),
        .wr_word_i (uop_word),
        .pop_i     (q_pop),
        .empty_o   (q_empty),
        .head_o    (q_word),
        .full_o    (full_o)
    );

    exec_unit u_exec (
        .clk              (clk),
        .rst_i            (rst_i),
        .empty_i          (q_empty),
        .uop_i            (q_word),
        .pop_o            (q_pop),
        .retire_o         (retire_o),
        .retire_pc_o      (retire_pc_o),
        .retire_illegal_o (retire_illegal_o),
        .wb_we_o          (wb_we_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o),
        .halt_o           (halt_o)
    );

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // ====================
    // field and data widths
    typedef logic [31:0] inst_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // RV32E only has x0..x15
    localparam int NUM_GPR = 16;

    // ====================
    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ====================
    // funct3 of OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct7, alt selects SUB and SRA
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // imm field of EBREAK under SYSTEM
    localparam logic [11:0] IMM_EBREAK = 12'h001;

endpackage

//--- hw/uop_queue.sv
`timescale 1ns/1ps

module uop_queue (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     wr_i,
    input  core_cfg_pkg::uop_word_t  wr_word_i,
    input  logic                     pop_i,
    output logic                     empty_o,
    output core_cfg_pkg::uop_word_t  head_o,
    output logic                     full_o
);

    core_cfg_pkg::uop_word_t          mem [core_cfg_pkg::QUEUE_DEPTH];
    logic [core_cfg_pkg::QPTR_W-1:0]  wr_ptr;
    logic [core_cfg_pkg::QPTR_W-1:0]  rd_ptr;
    // one extra bit so a full queue is countable
    logic [core_cfg_pkg::QPTR_W:0]    count;
    logic                             do_pop;

    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];
    assign do_pop  = pop_i && !empty_o;

    // early full, keeps a slot for the word in the decode register
    assign full_o  = (count >= (core_cfg_pkg::QPTR_W + 1)'(core_cfg_pkg::QUEUE_DEPTH - 1));

    // storage
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr] <= wr_word_i;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- testbench/ref_model.svh
// expected retirement of one strobed instruction
typedef struct {
    rv_isa_pkg::pc_t       pc;
    logic                  ill;
    logic                  we;
    rv_isa_pkg::reg_idx_t  rd;
    rv_isa_pkg::word_t     data;
} exp_ret_t;

rv_isa_pkg::word_t model_rf [16];
exp_ret_t          exp_q [$];
logic              model_halted = 1'b0;
int                shift_total = 0;

// OP and OP-IMM results as the ISA defines them
function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                               input rv_isa_pkg::word_t a,
                                               input rv_isa_pkg::word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? rv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic model_step(input rv_isa_pkg::inst_t inst, input rv_isa_pkg::pc_t pc);
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              legal;
    logic              writes;
    logic              halt;
    logic              is_sh;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t res;
    exp_ret_t          e;
    rd     = inst[11:7];
    f3     = inst[14:12];
    rs1    = inst[19:15];
    rs2    = inst[24:20];
    f7     = inst[31:25];
    legal  = 1'b0;
    writes = 1'b0;
    halt   = 1'b0;
    is_sh  = 1'b0;
    res    = '0;
    b      = '0;
    // nothing retires once EBREAK has been strobed
    if (model_halted) return;
    case (inst[6:0])
        7'b0010011: begin
            a     = model_rf[rs1[3:0]];
            is_sh = (f3 == 3'd1) || (f3 == 3'd5);
            if (is_sh) begin
                b     = {27'b0, inst[24:20]};
                legal = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);
            end else begin
                b     = {{20{inst[31]}}, inst[31:20]};
                legal = 1'b1;
            end
            legal  = legal && rd < 16 && rs1 < 16;
            res    = alu_ref(f3, is_sh && f7 == 7'h20, a, b);
            writes = 1'b1;
        end
        7'b0110011: begin
            a      = model_rf[rs1[3:0]];
            b      = model_rf[rs2[3:0]];
            is_sh  = (f3 == 3'd1) || (f3 == 3'd5);
            legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            legal  = legal && rd < 16 && rs1 < 16 && rs2 < 16;
            res    = alu_ref(f3, f7 == 7'h20, a, b);
            writes = 1'b1;
        end
        // LUI and AUIPC
        7'b0110111: begin
            res    = {inst[31:12], 12'b0};
            legal  = rd < 16;
            writes = 1'b1;
        end
        7'b0010111: begin
            res    = pc + {inst[31:12], 12'b0};
            legal  = rd < 16;
            writes = 1'b1;
        end
        // only EBREAK under SYSTEM
        7'b1110011: begin
            legal = (inst[31:7] == {12'h001, 13'b0});
            halt  = legal;
        end
        default: legal = 1'b0;
    endcase
    e.pc   = pc;
    e.ill  = !legal;
    e.we   = legal && writes && (rd != 5'd0);
    e.rd   = rd;
    e.data = res;
    if (e.we) model_rf[rd[3:0]] = res;
    if (legal && is_sh) shift_total += int'(b[4:0]);
    if (halt) model_halted = 1'b1;
    exp_q.push_back(e);
endtask

//--- testbench/tb_idu_core.sv
`timescale 1ns/1ps

module tb_idu_core;

    logic                  clk;
    logic                  rst_i;
    logic                  inst_valid_i;
    rv_isa_pkg::inst_t     inst_i;
    rv_isa_pkg::pc_t       pc_i;
    logic                  full_o;
    logic                  retire_o;
    rv_isa_pkg::pc_t       retire_pc_o;
    logic                  retire_illegal_o;
    logic                  wb_we_o;
    rv_isa_pkg::reg_idx_t  wb_rd_o;
    rv_isa_pkg::word_t     wb_data_o;
    logic                  halt_o;

    int errors = 0;
    int checks = 0;
    int n_sent = 0;
    int cycles = 0;
    int cycle_limit = 200;
    rv_isa_pkg::pc_t pc_next = 32'h0000_1000;

    `include "ref_model.svh"

    idu_core i_idu_core (
        .clk              (clk),
        .rst_i            (rst_i),
        .inst_valid_i     (inst_valid_i),
        .inst_i           (inst_i),
        .pc_i             (pc_i),
        .full_o           (full_o),
        .retire_o         (retire_o),
        .retire_pc_o      (retire_pc_o),
        .retire_illegal_o (retire_illegal_o),
        .wb_we_o          (wb_we_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o),
        .halt_o           (halt_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // compare tasks
    task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                              input rv_isa_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input rv_isa_pkg::pc_t got,
                            input rv_isa_pkg::pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input rv_isa_pkg::reg_idx_t got,
                             input rv_isa_pkg::reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // retirements sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin : retire_monitor
        exp_ret_t e;
        if (!rst_i && retire_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("retirement with nothing expected, pc %h", retire_pc_o);
            end else begin
                e = exp_q.pop_front();
                check_pc("retire_pc_o", retire_pc_o, e.pc);
                check_flag("retire_illegal_o", retire_illegal_o, e.ill);
                check_flag("wb_we_o", wb_we_o, e.we);
                if (e.we) begin
                    check_idx("wb_rd_o", wb_rd_o, e.rd);
                    check_word("wb_data_o", wb_data_o, e.data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d retirements missing",
                     cycles, exp_q.size());
            $display("tests failed");
            $finish;
        end
    end

    // ====================
    // instruction builders
    function automatic rv_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(15));
    endfunction

    function automatic rv_isa_pkg::inst_t rand_r_inst();
        logic [2:0] f3;
        logic       alt;
        f3  = 3'($urandom_range(7));
        alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom_range(1) == 1);
        return enc_r(alt ? 7'h20 : 7'h00, rand_reg(), rand_reg(), f3, rand_reg());
    endfunction

    function automatic rv_isa_pkg::inst_t rand_i_inst(input bit long_shift);
        logic [2:0]  f3;
        logic [4:0]  shamt;
        logic [11:0] imm;
        f3 = 3'($urandom_range(7));
        if (f3 == 3'd1 || f3 == 3'd5) begin
            shamt = long_shift ? 5'($urandom_range(16, 31)) : 5'($urandom_range(31));
            imm   = {(f3 == 3'd5 && $urandom_range(1) == 1) ? 7'h20 : 7'h00, shamt};
        end else begin
            imm = 12'($urandom());
        end
        return enc_i(imm, rand_reg(), f3, rand_reg());
    endfunction

    function automatic rv_isa_pkg::inst_t rand_illegal();
        rv_isa_pkg::inst_t  inst;
        logic [6:0]         f7;
        logic [6:0]         unknown [6] = '{7'h0b, 7'h2b, 7'h5b, 7'h7b, 7'h0f, 7'h57};
        inst = $urandom();
        case ($urandom_range(10))
            0: inst[6:0] = 7'b0000011;
            1: inst[6:0] = 7'b0100011;
            2: inst[6:0] = 7'b1100011;
            3: inst[6:0] = 7'b1101111;
            4: inst[6:0] = 7'b1100111;
            // CSR access
            5: inst = {inst[31:15], 3'($urandom_range(1, 7)), inst[11:7], 7'b1110011};
            6: inst = ($urandom_range(1) == 1) ? 32'h0000_0073 : 32'h3020_0073;
            7: inst[6:0] = unknown[$urandom_range(5)];
            8: begin
                inst = enc_r(7'h00, rand_reg(), rand_reg(), 3'($urandom_range(7)), rand_reg());
                case ($urandom_range(2))
                    0:       inst[11:7]  = 5'($urandom_range(16, 31));
                    1:       inst[19:15] = 5'($urandom_range(16, 31));
                    default: inst[24:20] = 5'($urandom_range(16, 31));
                endcase
            end
            9: begin
                f7 = 7'($urandom_range(1, 127));
                if (f7 == 7'h20) f7 = 7'h01;
                inst = enc_r(f7, rand_reg(), rand_reg(), 3'($urandom_range(7)), rand_reg());
            end
            // legal but rd is x0
            default: inst = ($urandom_range(1) == 1) ?
                            enc_i(12'($urandom()), rand_reg(), 3'd0, 5'd0) :
                            enc_r(7'h00, rand_reg(), rand_reg(), 3'd0, 5'd0);
        endcase
        return inst;
    endfunction

    // ====================
    // stimulus, always entered 1 ns after a rising edge
    task automatic send(input rv_isa_pkg::inst_t inst, input rv_isa_pkg::pc_t pc);
        while (full_o) begin
            @(posedge clk);
            #1;
        end
        inst_valid_i = 1'b1;
        inst_i       = inst;
        pc_i         = pc;
        n_sent++;
        model_step(inst, pc);
        cycle_limit = 200 + 10 * n_sent + shift_total;
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
    endtask

    task automatic send_seq(input rv_isa_pkg::inst_t inst);
        send(inst, pc_next);
        pc_next += 4;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        int e0;
        void'($urandom(32'h6039895f));
        foreach (model_rf[i]) model_rf[i] = '0;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;

        e0 = errors;
        check_flag("retire_o", retire_o, 1'b0);
        check_flag("wb_we_o", wb_we_o, 1'b0);
        check_flag("halt_o", halt_o, 1'b0);
        check_flag("full_o", full_o, 1'b0);
        for (int i = 1; i < 8; i++) send_seq(enc_i(12'($urandom()), 5'd0, 3'd0, 5'(i)));
        for (int i = 8; i < 16; i++) send_seq(enc_u(20'($urandom()), 5'(i), 7'b0110111));
        for (int i = 1; i < 16; i++) send_seq(enc_r(7'h00, 5'd0, 5'(i), 3'd0, 5'(i)));
        drain();
        report_test("test 1 reset and register readback", e0);

        e0 = errors;
        repeat (40) send_seq(rand_r_inst());
        drain();
        report_test("test 2 random register ops", e0);

        e0 = errors;
        repeat (40) send_seq(rand_i_inst(1'b0));
        drain();
        report_test("test 3 random immediate ops", e0);

        e0 = errors;
        repeat (20) begin
            send(enc_u(20'($urandom()), rand_reg(),
                       ($urandom_range(1) == 1) ? 7'b0010111 : 7'b0110111),
                 {30'($urandom()), 2'b00});
        end
        drain();
        report_test("test 4 upper immediates", e0);

        e0 = errors;
        repeat (40) send_seq(rand_illegal());
        drain();
        report_test("test 5 illegal encodings", e0);

        e0 = errors;
        repeat (60) begin
            if ($urandom_range(2) == 0) send_seq(rand_r_inst());
            else send_seq(rand_i_inst(1'b1));
        end
        send_seq(32'h0010_0073);
        repeat (2) send_seq(rand_r_inst());
        drain();
        check_flag("halt_o", halt_o, 1'b1);
        // later instructions must stay unretired
        repeat (50) @(posedge clk);
        #1;
        check_flag("halt_o", halt_o, 1'b1);
        report_test("test 6 back-pressure and halt", e0);

        $display("%0d checks, %0d errors, %0d instructions", checks, errors, n_sent);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
